// ==== hw/core_pkg.sv ====
////////////////////
// core package
// opcodes, ALU operations, control and stage register types
////////////////////
`default_nettype none

package core_pkg;

    // base opcodes of the supported RV32I subset
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam logic [31:0] RESET_PC = 32'h0;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } alu_op_e;

    // all zero is a bubble
    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic branch_eq;
        logic branch_ne;
        logic jump;
        logic alu_src_imm;
        logic valid;
        logic link;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t       ctrl;
        alu_op_e     alu_op;
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] result;
        logic [31:0] store_data;
        logic [31:0] target;
        logic        take;
        logic [4:0]  rd;
    } ex_mem_t;

    typedef struct packed {
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] wdata;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== hw/pipe_reg.sv ====
////////////////////
// pipe_reg
// stage register with hold and squash
////////////////////
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     stall,
    input  wire logic     nop,
    input  wire payload_t d,
    output payload_t      q
);

    always_ff @(posedge clk) begin
        if (reset || nop) begin
            // all-zero payload is the bubble
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/fetch.sv ====
////////////////////
// fetch stage
// program counter and instruction bus request
////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch import core_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        stall,
    input  wire logic        iready_n,
    input  wire logic        redirect,
    input  wire logic [31:0] target,
    input  wire logic [31:0] idata,
    output logic [31:0]      iaddr,
    output if_id_t           if_out,
    output logic             fetch_valid
);

    logic [31:0] pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            // taken branch or jal from MEM
            pc <= target;
        end else if (!stall && !iready_n) begin
            pc <= pc + 32'd4;
        end
    end

    assign iaddr = pc;

    // word only counts when the bus says ready
    assign fetch_valid = !iready_n;

    always_comb begin
        if_out.pc = pc;
        if_out.instr = idata;
    end

endmodule

`default_nettype wire

// ==== hw/decode.sv ====
////////////////////
// decode stage
// fields, immediates, register reads, control
////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode import core_pkg::*; (
    input  wire if_id_t      if_in,
    input  wire logic [31:0] rdata1,
    input  wire logic [31:0] rdata2,
    output logic [4:0]       raddr1,
    output logic [4:0]       raddr2,
    output id_ex_t           id_out
);

    logic [31:0] instr;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [31:0] imm;
    ctrl_t       ctrl;
    alu_op_e     alu_op;
    logic        use_rs1, use_rs2;

    assign instr  = if_in.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl    = '0;
        alu_op  = ALU_ADD;
        imm     = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OP_REG: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000: alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b111: alu_op = ALU_AND;
                    3'b110: alu_op = ALU_OR;
                    3'b100: alu_op = ALU_XOR;
                    3'b010: alu_op = ALU_SLT;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_IMM: begin
                use_rs1 = 1'b1;
                imm = imm_i;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b111: alu_op = ALU_AND;
                    3'b110: alu_op = ALU_OR;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_LUI: begin
                imm = imm_u;
                alu_op = ALU_PASSB;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_LOAD: begin
                use_rs1 = 1'b1;
                imm = imm_i;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read = (funct3 == 3'b010);
                ctrl.reg_write = (funct3 == 3'b010);
            end
            OP_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm = imm_s;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write = (funct3 == 3'b010);
            end
            OP_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm = imm_b;
                ctrl.branch_eq = (funct3 == 3'b000);
                ctrl.branch_ne = (funct3 == 3'b001);
            end
            OP_JAL: begin
                imm = imm_j;
                ctrl.jump = 1'b1;
                ctrl.link = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: ;
        endcase
        // anything left without an action is a bubble
        ctrl.valid = ctrl.reg_write | ctrl.mem_write | ctrl.branch_eq | ctrl.branch_ne;
    end

    // unused source fields read x0 so they never cause a stall
    assign raddr1 = use_rs1 ? instr[19:15] : 5'd0;
    assign raddr2 = use_rs2 ? instr[24:20] : 5'd0;

    always_comb begin
        id_out.ctrl    = ctrl;
        id_out.alu_op  = alu_op;
        id_out.pc      = if_in.pc;
        id_out.rs1_val = rdata1;
        id_out.rs2_val = rdata2;
        id_out.imm     = imm;
        id_out.rs1     = raddr1;
        id_out.rs2     = raddr2;
        id_out.rd      = ctrl.reg_write ? instr[11:7] : 5'd0;
    end

endmodule

`default_nettype wire

// ==== hw/execute.sv ====
////////////////////
// execute stage
// ALU, branch compare and target
////////////////////
`timescale 1ns/1ps
`default_nettype none

module execute import core_pkg::*; (
    input  wire id_ex_t ex_in,
    output ex_mem_t     ex_out
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_y;
    logic [31:0] pc_plus4;
    logic        eq;

    assign op_a = ex_in.rs1_val;
    assign op_b = ex_in.ctrl.alu_src_imm ? ex_in.imm : ex_in.rs2_val;

    always_comb begin
        case (ex_in.alu_op)
            ALU_ADD:   alu_y = op_a + op_b;
            ALU_SUB:   alu_y = op_a - op_b;
            ALU_AND:   alu_y = op_a & op_b;
            ALU_OR:    alu_y = op_a | op_b;
            ALU_XOR:   alu_y = op_a ^ op_b;
            ALU_SLT:   alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASSB: alu_y = op_b;
            default:   alu_y = op_b;
        endcase
    end

    assign pc_plus4 = ex_in.pc + 32'd4;

    // branch compare always on the register values
    assign eq = (ex_in.rs1_val == ex_in.rs2_val);

    always_comb begin
        ex_out.ctrl       = ex_in.ctrl;
        ex_out.result     = ex_in.ctrl.link ? pc_plus4 : alu_y;
        ex_out.store_data = ex_in.rs2_val;
        // both branches and jal are pc relative
        ex_out.target     = ex_in.pc + ex_in.imm;
        ex_out.take       = ex_in.ctrl.jump
                          | (ex_in.ctrl.branch_eq & eq)
                          | (ex_in.ctrl.branch_ne & ~eq);
        ex_out.rd         = ex_in.rd;
    end

endmodule

`default_nettype wire

// ==== hw/mem_access.sv ====
////////////////////
// memory access stage
// data bus, branch redirect, writeback select
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_access import core_pkg::*; (
    input  wire ex_mem_t     mem_in,
    input  wire logic        dready_n,
    input  wire logic        dbusy,
    inout  wire logic [31:0] ddata,
    output logic [31:0]      daddr,
    output logic             dreq,
    output logic             dwrite,
    output logic             mem_wait,
    output logic             redirect,
    output logic [31:0]      target,
    output mem_wb_t          wb_out
);

    logic access;
    logic done;

    assign access = mem_in.ctrl.valid & (mem_in.ctrl.mem_read | mem_in.ctrl.mem_write);

    // hold off the request while the bus is busy
    assign dreq   = access & ~dbusy;
    assign dwrite = dreq & mem_in.ctrl.mem_write;
    assign daddr  = mem_in.result;

    assign ddata = dwrite ? mem_in.store_data : 32'hzzzz_zzzz;

    assign done     = dreq & ~dready_n;
    assign mem_wait = access & ~done;

    assign redirect = mem_in.ctrl.valid & mem_in.take;
    assign target   = mem_in.target;

    always_comb begin
        wb_out.reg_write = mem_in.ctrl.reg_write;
        wb_out.rd        = mem_in.rd;
        // load data is taken on the completing edge
        wb_out.wdata     = mem_in.ctrl.mem_read ? ddata : mem_in.result;
    end

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
////////////////////
// register file
// 31 writable registers, write-through reads
////////////////////
`timescale 1ns/1ps
`default_nettype none

module regfile import core_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [4:0]  raddr1,
    input  wire logic [4:0]  raddr2,
    output logic [31:0]      rdata1,
    output logic [31:0]      rdata2,
    input  wire mem_wb_t     wb
);

    logic [31:0] regs [1:31];

    function automatic logic [31:0] read_port(input logic [4:0] addr, input mem_wb_t w,
                                              input logic [31:0] stored);
        logic [31:0] val;
        if (addr == 5'd0) begin
            val = 32'd0;
        end else if (w.reg_write && w.rd == addr) begin
            // same-cycle write from WB
            val = w.wdata;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wb.reg_write && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

    assign rdata1 = read_port(raddr1, wb, regs[raddr1]);
    assign rdata2 = read_port(raddr2, wb, regs[raddr2]);

endmodule

`default_nettype wire

// ==== hw/noper.sv ====
////////////////////
// hazard unit
// stall and nop for every pipeline stage
////////////////////
`timescale 1ns/1ps
`default_nettype none

module noper import core_pkg::*; (
    input  wire id_ex_t      id_ex_q,
    input  wire ex_mem_t     ex_mem_q,
    input  wire logic [4:0]  raddr1,
    input  wire logic [4:0]  raddr2,
    input  wire logic        fetch_valid,
    input  wire logic        mem_wait,
    input  wire logic        redirect,
    output logic             stall_if,
    output logic             stall_id,
    output logic             stall_ex,
    output logic             stall_mem,
    output logic             stall_wb,
    output logic             nop_if,
    output logic             nop_id,
    output logic             nop_ex,
    output logic             nop_mem,
    output logic             nop_wb
);

    logic hz_ex;
    logic hz_mem;
    logic dep;

    // rd of zero never matches, raddr of zero means unused
    assign hz_ex  = id_ex_q.ctrl.reg_write && id_ex_q.rd != 5'd0
                 && (id_ex_q.rd == raddr1 || id_ex_q.rd == raddr2);
    assign hz_mem = ex_mem_q.ctrl.reg_write && ex_mem_q.rd != 5'd0
                 && (ex_mem_q.rd == raddr1 || ex_mem_q.rd == raddr2);
    assign dep    = hz_ex | hz_mem;

    always_comb begin
        {stall_if, stall_id, stall_ex, stall_mem, stall_wb} = '0;
        {nop_if, nop_id, nop_ex, nop_mem, nop_wb} = '0;
        if (mem_wait) begin
            // data bus back-pressure freezes everything
            {stall_if, stall_id, stall_ex, stall_mem, stall_wb} = '1;
        end else if (redirect) begin
            // IF squash means the PC reloads from target
            nop_if  = 1'b1;
            nop_id  = 1'b1;
            nop_ex  = 1'b1;
            nop_mem = 1'b1;
        end else if (dep) begin
            stall_if = 1'b1;
            stall_id = 1'b1;
            nop_ex   = 1'b1;
        end else begin
            nop_id = ~fetch_valid;
        end
    end

endmodule

`default_nettype wire

// ==== hw/core.sv ====
////////////////////
// RV32I core top
// five-stage pipeline with separate buses
////////////////////
`timescale 1ns/1ps
`default_nettype none

module core import core_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        iready_n,
    input  wire logic        dready_n,
    input  wire logic        dbusy,
    input  wire logic [31:0] idata,
    output logic [31:0]      iaddr,
    output logic [31:0]      daddr,
    output logic             dreq,
    output logic             dwrite,
    inout  wire logic [31:0] ddata
);

    if_id_t  if_d, if_q;
    id_ex_t  id_d, id_q;
    ex_mem_t ex_d, ex_q;
    mem_wb_t wb_d, wb_q;

    logic [4:0]  raddr1, raddr2;
    logic [31:0] rdata1, rdata2;
    logic [31:0] target;
    logic        fetch_valid, mem_wait, redirect;
    logic        stall_if, stall_id, stall_ex, stall_mem, stall_wb;
    logic        nop_if, nop_id, nop_ex, nop_mem, nop_wb;

    fetch u_fetch (
        .clk(clk), .reset(reset), .stall(stall_if), .iready_n(iready_n),
        .redirect(nop_if), .target(target), .idata(idata),
        .iaddr(iaddr), .if_out(if_d), .fetch_valid(fetch_valid)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .reset(reset), .stall(stall_id), .nop(nop_id), .d(if_d), .q(if_q)
    );

    decode u_decode (
        .if_in(if_q), .rdata1(rdata1), .rdata2(rdata2),
        .raddr1(raddr1), .raddr2(raddr2), .id_out(id_d)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .reset(reset), .stall(stall_ex), .nop(nop_ex), .d(id_d), .q(id_q)
    );

    execute u_execute (
        .ex_in(id_q), .ex_out(ex_d)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .reset(reset), .stall(stall_mem), .nop(nop_mem), .d(ex_d), .q(ex_q)
    );

    mem_access u_mem_access (
        .mem_in(ex_q), .dready_n(dready_n), .dbusy(dbusy), .ddata(ddata),
        .daddr(daddr), .dreq(dreq), .dwrite(dwrite), .mem_wait(mem_wait),
        .redirect(redirect), .target(target), .wb_out(wb_d)
    );

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .reset(reset), .stall(stall_wb), .nop(nop_wb), .d(wb_d), .q(wb_q)
    );

    regfile u_regfile (
        .clk(clk), .reset(reset), .raddr1(raddr1), .raddr2(raddr2),
        .rdata1(rdata1), .rdata2(rdata2), .wb(wb_q)
    );

    noper u_noper (
        .id_ex_q(id_q), .ex_mem_q(ex_q), .raddr1(raddr1), .raddr2(raddr2),
        .fetch_valid(fetch_valid), .mem_wait(mem_wait), .redirect(redirect),
        .stall_if(stall_if), .stall_id(stall_id), .stall_ex(stall_ex),
        .stall_mem(stall_mem), .stall_wb(stall_wb),
        .nop_if(nop_if), .nop_id(nop_id), .nop_ex(nop_ex),
        .nop_mem(nop_mem), .nop_wb(nop_wb)
    );

endmodule

`default_nettype wire

// ==== bench/bus_model.sv ====
////////////////////
// bus model
// instruction ROM and data RAM with random wait states
////////////////////
`timescale 1ns/1ps
`default_nettype none

module bus_model (
    input  wire logic        clk,
    input  wire logic        random_waits,
    input  wire logic [31:0] iaddr,
    output logic [31:0]      idata,
    output logic             iready_n,
    input  wire logic [31:0] daddr,
    inout  wire logic [31:0] ddata,
    input  wire logic        dreq,
    input  wire logic        dwrite,
    output logic             dready_n,
    output logic             dbusy
);

    logic [31:0] rom [0:63];
    logic [31:0] ram [0:63];
    logic [31:0] rdata;
    logic [31:0] lfsr;
    logic        b0;
    logic        b1;
    logic        b2;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    initial begin
        lfsr = 32'h5791;
        idata = 32'd0;
        rdata = 32'd0;
        iready_n = 1'b1;
        dready_n = 1'b1;
        dbusy = 1'b0;
        for (int i = 0; i < 64; i++) begin
            ram[i] = 32'hDA7A_0000 + i * 32'h0000_0101;
        end
    end

    // read data only while the core asks for a load
    assign ddata = (dreq && !dwrite) ? rdata : 32'hzzzz_zzzz;

    always @(negedge clk) begin
        idata = rom[iaddr[7:2]];
        rdata = ram[daddr[7:2]];
        if (random_waits) begin
            take_bit(b0);
            take_bit(b1);
            iready_n = b0 & b1;
            take_bit(b0);
            take_bit(b1);
            dready_n = b0 & b1;
            take_bit(b0);
            take_bit(b1);
            take_bit(b2);
            dbusy = b0 & b1 & b2;
        end else begin
            iready_n = 1'b0;
            dready_n = 1'b0;
            dbusy = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (dreq && dwrite && !dready_n) begin
            ram[daddr[7:2]] <= ddata;
        end
    end

endmodule

`default_nettype wire

// ==== bench/core_tb.sv ====
////////////////////
// core testbench
// runs a small program twice and checks every store on the data bus
////////////////////
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam int NUM_ROWS    = 13;
    localparam int NUM_PASSES  = 2;
    localparam int CYCLE_LIMIT = 40 * NUM_ROWS * NUM_PASSES;
    localparam logic [31:0] MARKER = 32'hDEAD_0000;

    localparam logic [6:0] REG_OPC = 7'b0110011;
    localparam logic [6:0] IMM_OPC = 7'b0010011;
    localparam logic [6:0] LD_OPC  = 7'b0000011;

    logic        clk;
    logic        reset;
    logic        random_waits;
    logic        iready_n;
    logic        dready_n;
    logic        dbusy;
    logic        dreq;
    logic        dwrite;
    logic [31:0] idata;
    logic [31:0] iaddr;
    logic [31:0] daddr;
    wire  [31:0] ddata;

    string       row_name [0:NUM_ROWS-1];
    logic [31:0] row_addr [0:NUM_ROWS-1];
    logic [31:0] row_data [0:NUM_ROWS-1];
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;

    core UUT (
        .clk(clk), .reset(reset), .iready_n(iready_n), .dready_n(dready_n),
        .dbusy(dbusy), .idata(idata), .iaddr(iaddr), .daddr(daddr),
        .dreq(dreq), .dwrite(dwrite), .ddata(ddata)
    );

    bus_model mem (
        .clk(clk), .random_waits(random_waits), .iaddr(iaddr), .idata(idata),
        .iready_n(iready_n), .daddr(daddr), .ddata(ddata), .dreq(dreq),
        .dwrite(dwrite), .dready_n(dready_n), .dbusy(dbusy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the program did not finish its stores in %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, REG_OPC};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    // SW only
    function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // LUI
    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic load_program();
        mem.rom[0]  = i_type(IMM_OPC, 3'b000, 5'd1, 5'd0, 32'd12);
        mem.rom[1]  = i_type(IMM_OPC, 3'b000, 5'd2, 5'd0, -32'sd5);
        mem.rom[2]  = r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
        mem.rom[3]  = s_type(5'd3, 5'd0, 32'h00);
        mem.rom[4]  = r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2);
        mem.rom[5]  = s_type(5'd4, 5'd0, 32'h04);
        mem.rom[6]  = r_type(7'h00, 3'b111, 5'd5, 5'd1, 5'd2);
        mem.rom[7]  = s_type(5'd5, 5'd0, 32'h08);
        mem.rom[8]  = r_type(7'h00, 3'b110, 5'd6, 5'd1, 5'd2);
        mem.rom[9]  = s_type(5'd6, 5'd0, 32'h0C);
        mem.rom[10] = r_type(7'h00, 3'b100, 5'd7, 5'd1, 5'd2);
        mem.rom[11] = s_type(5'd7, 5'd0, 32'h10);
        mem.rom[12] = r_type(7'h00, 3'b010, 5'd8, 5'd2, 5'd1);
        mem.rom[13] = s_type(5'd8, 5'd0, 32'h14);
        mem.rom[14] = r_type(7'h00, 3'b010, 5'd16, 5'd1, 5'd2);
        mem.rom[15] = s_type(5'd16, 5'd0, 32'h18);
        mem.rom[16] = u_type(5'd9, 20'h12345);
        mem.rom[17] = s_type(5'd9, 5'd0, 32'h1C);
        // dependent chain on x10
        mem.rom[18] = i_type(IMM_OPC, 3'b000, 5'd10, 5'd0, 32'd3);
        mem.rom[19] = i_type(IMM_OPC, 3'b000, 5'd10, 5'd10, 32'd4);
        mem.rom[20] = i_type(IMM_OPC, 3'b000, 5'd10, 5'd10, 32'd5);
        mem.rom[21] = i_type(IMM_OPC, 3'b110, 5'd10, 5'd10, 32'h100);
        mem.rom[22] = i_type(IMM_OPC, 3'b111, 5'd10, 5'd10, 32'h1F8);
        mem.rom[23] = s_type(5'd10, 5'd0, 32'h20);
        // load then use
        mem.rom[24] = i_type(LD_OPC, 3'b010, 5'd11, 5'd0, 32'hA0);
        mem.rom[25] = i_type(IMM_OPC, 3'b000, 5'd12, 5'd11, 32'd5);
        mem.rom[26] = s_type(5'd12, 5'd0, 32'h24);
        mem.rom[27] = u_type(5'd13, 20'hDEAD0);
        mem.rom[28] = b_type(3'b000, 5'd1, 5'd1, 32'd12);
        mem.rom[29] = s_type(5'd13, 5'd0, 32'h28);
        mem.rom[30] = s_type(5'd13, 5'd0, 32'h28);
        mem.rom[31] = s_type(5'd1, 5'd0, 32'h28);
        mem.rom[32] = b_type(3'b001, 5'd1, 5'd1, 32'd8);
        mem.rom[33] = i_type(IMM_OPC, 3'b000, 5'd14, 5'd0, 32'h55);
        mem.rom[34] = s_type(5'd14, 5'd0, 32'h2C);
        mem.rom[35] = j_type(5'd15, 32'd12);
        mem.rom[36] = s_type(5'd13, 5'd0, 32'h30);
        mem.rom[37] = s_type(5'd13, 5'd0, 32'h30);
        mem.rom[38] = s_type(5'd15, 5'd0, 32'h30);
        mem.rom[39] = j_type(5'd0, 32'd0);
        // every word past the end jumps back to the spin loop
        for (int i = 40; i < 64; i++) begin
            mem.rom[i] = j_type(5'd0, (39 - i) * 4);
        end
    endtask

    task automatic add_row(input int k, input string name, input logic [31:0] addr,
                           input logic [31:0] data);
        row_name[k] = name;
        row_addr[k] = addr;
        row_data[k] = data;
    endtask

    // x1 = 12, x2 = -5
    task automatic load_expected();
        add_row(0, "add", 32'h00, 32'h0000_0007);
        add_row(1, "sub", 32'h04, 32'h0000_0011);
        add_row(2, "and", 32'h08, 32'h0000_0008);
        add_row(3, "or", 32'h0C, 32'hFFFF_FFFF);
        add_row(4, "xor", 32'h10, 32'hFFFF_FFF7);
        add_row(5, "slt_true", 32'h14, 32'h0000_0001);
        add_row(6, "slt_false", 32'h18, 32'h0000_0000);
        add_row(7, "lui", 32'h1C, 32'h1234_5000);
        add_row(8, "addi_chain", 32'h20, 32'h0000_0108);
        add_row(9, "load_use", 32'h24, 32'hDA7A_282D);
        add_row(10, "beq_taken", 32'h28, 32'h0000_000C);
        add_row(11, "bne_fall", 32'h2C, 32'h0000_0055);
        add_row(12, "jal_link", 32'h30, 32'h0000_0090);
    endtask

    task automatic finish_test(input string tag, input string name, input logic ok);
        tests_run++;
        if (!ok) begin
            tests_failed++;
        end
        $display("%s %s: %s", tag, name, ok ? "pass" : "FAIL");
    endtask

    task automatic apply_reset(input logic waits, input string tag);
        logic ok;
        ok = 1'b1;
        @(negedge clk);
        reset = 1'b1;
        @(posedge clk);
        random_waits = waits;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (iaddr !== RESET_PC) begin
            $display("CHECK FAILED %s/reset_state iaddr: expected %h, actual %h",
                     tag, RESET_PC, iaddr);
            ok = 1'b0;
        end
        if (dreq !== 1'b0) begin
            $display("CHECK FAILED %s/reset_state dreq: expected 0, actual %b", tag, dreq);
            ok = 1'b0;
        end
        if (dwrite !== 1'b0) begin
            $display("CHECK FAILED %s/reset_state dwrite: expected 0, actual %b", tag, dwrite);
            ok = 1'b0;
        end
        reset = 1'b0;
        finish_test(tag, "reset_state", ok);
    endtask

    // values are taken before the edge updates the pipeline
    task automatic wait_for_store(output logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        while (!(dreq === 1'b1 && dwrite === 1'b1 && dready_n === 1'b0)) begin
            @(posedge clk);
        end
        addr = daddr;
        data = ddata;
    endtask

    task automatic run_pass(input logic waits, input string tag);
        logic [31:0] addr;
        logic [31:0] data;
        logic        ok;
        apply_reset(waits, tag);
        for (int k = 0; k < NUM_ROWS; k++) begin
            wait_for_store(addr, data);
            ok = 1'b1;
            if (data === MARKER) begin
                $display("%s/%s: an instruction after a taken jump stored the marker",
                         tag, row_name[k]);
                ok = 1'b0;
            end
            if (addr !== row_addr[k]) begin
                $display("CHECK FAILED %s/%s address: expected %h, actual %h",
                         tag, row_name[k], row_addr[k], addr);
                ok = 1'b0;
            end
            if (data !== row_data[k]) begin
                $display("CHECK FAILED %s/%s data: expected %h, actual %h",
                         tag, row_name[k], row_data[k], data);
                ok = 1'b0;
            end
            finish_test(tag, row_name[k], ok);
        end
    endtask

    initial begin
        reset = 1'b1;
        random_waits = 1'b0;
        load_program();
        load_expected();
        run_pass(1'b0, "no_waits");
        run_pass(1'b1, "waits");
        $display("tests: %0d, passed: %0d, failed: %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hw/core_pkg.sv
hw/pipe_reg.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/mem_access.sv
hw/regfile.sv
hw/noper.sv
hw/core.sv
bench/bus_model.sv
bench/core_tb.sv
